//--- Bender.yml
package:
  name: mem_sys

sources:
  # Design, in compile order
  - files:
      - common/mem_sys_pkg.sv
      - src/port_arbiter.sv
      - pma/pma_region_match.sv
      - src/mem_access_unit.sv
      - src/mem_sys_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - bench/mem_sys_assertions.sv
      - bench/tb_mem_sys.sv

//--- bench/mem_sys_assertions.sv
// Protocol checks on the port handshakes and the host-catch MMIO pulses
`timescale 1ns/1ns

module mem_sys_assertions (
  input logic HCLK,
  input logic rst_n_i,
  input logic ins_req_i,
  input logic ins_ack_i,
  input logic dat_req_i,
  input logic dat_ack_i,
  input logic tohost_valid_i,
  input logic uart_valid_i
);

  // Failed assertions so far
  int err_count = 0;

  ////////////////////
  // Handshake
  ////////////////////
  ins_ack_rise: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    $rose(ins_ack_i) |-> $past(ins_req_i))
    else begin
      $error("instruction ack rose without a request");
      err_count++;
    end

  dat_ack_rise: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    $rose(dat_ack_i) |-> $past(dat_req_i))
    else begin
      $error("data ack rose without a request");
      err_count++;
    end

  // Ack holds until its req drops
  ins_ack_hold: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    (ins_ack_i && ins_req_i) |=> ins_ack_i)
    else begin
      $error("instruction ack fell while req was high");
      err_count++;
    end

  dat_ack_hold: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    (dat_ack_i && dat_req_i) |=> dat_ack_i)
    else begin
      $error("data ack fell while req was high");
      err_count++;
    end

  ack_onehot: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    !(ins_ack_i && dat_ack_i))
    else begin
      $error("both acks high");
      err_count++;
    end

  ////////////////////
  // MMIO pulses
  ////////////////////
  tohost_pulse: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    tohost_valid_i |=> !tohost_valid_i)
    else begin
      $error("tohost valid longer than one cycle");
      err_count++;
    end

  uart_pulse: assert property (@(posedge HCLK) disable iff (!rst_n_i)
    uart_valid_i |=> !uart_valid_i)
    else begin
      $error("uart valid longer than one cycle");
      err_count++;
    end

endmodule

bind mem_sys_top mem_sys_assertions u_sva (
  .HCLK           (HCLK),
  .rst_n_i        (rst_n_i),
  .ins_req_i      (ins_req_i),
  .ins_ack_i      (ins_ack_o),
  .dat_req_i      (dat_req_i),
  .dat_ack_i      (dat_ack_o),
  .tohost_valid_i (tohost_valid_o),
  .uart_valid_i   (uart_valid_o)
);

//--- bench/tb_mem_sys.sv
// Testbench for the memory subsystem with four-phase port drivers and a PMA reference model
`timescale 1ns/1ns

module tb_mem_sys;
  import mem_sys_pkg::*;

  localparam logic [31:0]       SEED          = 32'h92df_c573;
  localparam int                TIMEOUT       = 50;
  // Falling edges from driving req to seeing ack move
  localparam int                ACK_LAT       = 4;
  localparam int                REL_LAT       = 2;
  localparam logic [ADDR_W-1:0] UNMAPPED_ADDR = 32'h9000_0000;

  logic              HCLK = 1'b0;
  logic              rst_n_i;
  logic              ins_req_i;
  logic [ADDR_W-1:0] ins_addr_i;
  logic              ins_ack_o;
  logic [DATA_W-1:0] ins_rdata_o;
  logic              ins_err_o;
  logic              dat_req_i;
  logic              dat_we_i;
  logic [ADDR_W-1:0] dat_addr_i;
  logic [DATA_W-1:0] dat_wdata_i;
  logic              dat_ack_o;
  logic [DATA_W-1:0] dat_rdata_o;
  logic              dat_err_o;
  logic              tohost_valid_o;
  logic [DATA_W-1:0] tohost_data_o;
  logic              uart_valid_o;
  logic [7:0]        uart_char_o;

  logic [DATA_W-1:0] shadow [RAM_WORDS];
  // Expected {err, rdata} per port
  logic [DATA_W:0]   ins_exp_q [$];
  logic [DATA_W:0]   dat_exp_q [$];
  logic [DATA_W-1:0] tohost_exp_q [$];
  logic [7:0]        uart_exp_q [$];
  logic [ADDR_W-1:0] wr_addr [$];
  int                lat_seen [2];
  logic              ins_ack_d;
  logic              dat_ack_d;

  mem_sys_top uut (.*);

  initial begin
    forever #2 HCLK = ~HCLK;
  end

  task automatic mismatch_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run aborted");
  endtask

  ////////////////////
  // Reference model
  ////////////////////
  // Lowest region whose byte range holds addr, or -1
  function automatic int find_region(input logic [ADDR_W-1:0] addr);
    logic [63:0] pa;
    logic [63:0] prev;
    logic [63:0] lo;
    logic [63:0] hi;
    int          ones;
    prev = '0;
    for (int i = 0; i < PMA_CNT; i++) begin
      pa = PMA_ADDR[i];
      lo = '0;
      hi = '0;
      case (PMA_MODE[i])
        PMA_TOR: begin
          lo = prev << 2;
          hi = pa << 2;
        end
        PMA_NA4: begin
          lo = pa << 2;
          hi = lo + 4;
        end
        PMA_NAPOT: begin
          ones = 0;
          while (pa[ones] == 1'b1) begin
            ones++;
          end
          // Trailing ones t give a block of 8 << t bytes
          lo = (pa >> (ones + 1)) << (ones + 3);
          hi = lo + (64'd8 << ones);
        end
        default: begin
          hi = '0;
        end
      endcase
      if ((64'(addr) >= lo) && (64'(addr) < hi)) begin
        return i;
      end
      prev = pa;
    end
    return -1;
  endfunction

  function automatic void exp_access(input logic port, input logic we,
                                     input logic [ADDR_W-1:0] addr,
                                     input logic [DATA_W-1:0] wdata,
                                     output logic err, output logic [DATA_W-1:0] rdata,
                                     output logic th, output logic ua);
    int        idx;
    pma_attr_t a;
    logic      ok;
    idx = find_region(addr);
    a   = (idx >= 0) ? PMA_ATTR[idx] : '0;
    ok  = (idx >= 0) && (!port ? a.x : (we ? a.w : a.r));
    err   = !ok;
    rdata = '0;
    th    = ok && we && a.mem_io && (idx == 1);
    ua    = ok && we && a.mem_io && (idx == 2);
    if (ok && !a.mem_io && we) begin
      shadow[addr[12:2]] = wdata;
    end else if (ok && !a.mem_io) begin
      rdata = shadow[addr[12:2]];
    end
  endfunction

  function automatic logic ack_of(input logic port);
    return port ? dat_ack_o : ins_ack_o;
  endfunction

  ////////////////////
  // Port drivers
  ////////////////////
  // Starts and ends on a falling edge
  task automatic run_handshake(input logic port, input logic we, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata, input bit solo);
    logic              err;
    logic [DATA_W-1:0] rdata;
    logic              th;
    logic              ua;
    int                cnt;
    int                extra;
    exp_access(port, we, addr, wdata, err, rdata, th, ua);
    if (port) begin
      dat_exp_q.push_back({err, rdata});
      dat_we_i    = we;
      dat_addr_i  = addr;
      dat_wdata_i = wdata;
      dat_req_i   = 1'b1;
    end else begin
      ins_exp_q.push_back({err, rdata});
      ins_addr_i = addr;
      ins_req_i  = 1'b1;
    end
    if (th) tohost_exp_q.push_back(wdata);
    if (ua) uart_exp_q.push_back(wdata[7:0]);
    cnt = 0;
    do begin
      @(negedge HCLK);
      cnt++;
      if (cnt > TIMEOUT) abort_run($sformatf("Timeout waiting for port %0d ack to rise", port));
    end while (!ack_of(port));
    lat_seen[port] = cnt;
    if (solo) begin
      assert (cnt == ACK_LAT)
        else mismatch_error($sformatf("port %0d ack after %0d edges, expected %0d",
                                      port, cnt, ACK_LAT));
    end
    // Ack must hold while req stays high under back-pressure
    extra = $urandom_range(3, 0);
    repeat (extra) begin
      @(negedge HCLK);
      assert (ack_of(port)) else mismatch_error($sformatf("port %0d ack fell under req", port));
    end
    if (port) dat_req_i = 1'b0;
    else ins_req_i = 1'b0;
    cnt = 0;
    do begin
      @(negedge HCLK);
      cnt++;
      if (cnt > TIMEOUT) abort_run($sformatf("Timeout waiting for port %0d ack to fall", port));
    end while (ack_of(port));
    assert (cnt == REL_LAT)
      else mismatch_error($sformatf("port %0d ack fell after %0d edges", port, cnt));
  endtask

  task automatic ins_access(input logic [ADDR_W-1:0] addr, input bit solo);
    run_handshake(1'b0, 1'b0, addr, '0, solo);
  endtask

  task automatic dat_access(input logic we, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input bit solo);
    run_handshake(1'b1, we, addr, wdata, solo);
  endtask

  ////////////////////
  // Comparing process
  ////////////////////
  task automatic compare_rsp(input logic port, input logic [DATA_W:0] got);
    logic [DATA_W:0] exp;
    if (port) begin
      assert (dat_exp_q.size() > 0) else abort_run("Data ack with no request outstanding");
      exp = dat_exp_q.pop_front();
    end else begin
      assert (ins_exp_q.size() > 0) else abort_run("Instruction ack with no request outstanding");
      exp = ins_exp_q.pop_front();
    end
    assert (got === exp)
      else mismatch_error($sformatf("port %0d err/rdata %0b/%h, expected %0b/%h", port,
                                    got[DATA_W], got[DATA_W-1:0], exp[DATA_W], exp[DATA_W-1:0]));
  endtask

  task automatic match_mmio();
    logic [DATA_W-1:0] exp_word;
    logic [7:0]        exp_char;
    if (tohost_valid_o) begin
      assert (tohost_exp_q.size() > 0) else abort_run("Tohost pulse without an allowed write");
      exp_word = tohost_exp_q.pop_front();
      assert (tohost_data_o === exp_word)
        else mismatch_error($sformatf("tohost %h, expected %h", tohost_data_o, exp_word));
    end
    if (uart_valid_o) begin
      assert (uart_exp_q.size() > 0) else abort_run("UART pulse without an allowed write");
      exp_char = uart_exp_q.pop_front();
      assert (uart_char_o === exp_char)
        else mismatch_error($sformatf("uart char %h, expected %h", uart_char_o, exp_char));
    end
  endtask

  always @(negedge HCLK) begin
    if (rst_n_i) begin
      if (ins_ack_o && !ins_ack_d) compare_rsp(1'b0, {ins_err_o, ins_rdata_o});
      if (dat_ack_o && !dat_ack_d) compare_rsp(1'b1, {dat_err_o, dat_rdata_o});
      match_mmio();
      assert (uut.u_sva.err_count == 0) else abort_run("A bound protocol assertion failed");
    end
    ins_ack_d = ins_ack_o;
    dat_ack_d = dat_ack_o;
  end

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin : stimulus
    logic [ADDR_W-1:0] addr;
    void'($urandom(SEED));
    rst_n_i     = 1'b0;
    ins_req_i   = 1'b0;
    ins_addr_i  = '0;
    dat_req_i   = 1'b0;
    dat_we_i    = 1'b0;
    dat_addr_i  = '0;
    dat_wdata_i = '0;
    ins_ack_d   = 1'b0;
    dat_ack_d   = 1'b0;
    repeat (4) @(negedge HCLK);
    rst_n_i = 1'b1;
    assert (!ins_ack_o && !dat_ack_o && !tohost_valid_o && !uart_valid_o)
      else mismatch_error("outputs not idle after reset");

    // Random RAM traffic alternating between region 0 and region 3
    for (int i = 0; i < 16; i++) begin
      if (i % 2 == 0) addr = RAM_BASE + (ADDR_W'($urandom_range(1023, 0)) << 2);
      else addr = UART_TX_ADDR + 4 + (ADDR_W'($urandom_range(990, 0)) << 2);
      wr_addr.push_back(addr);
      dat_access(1'b1, addr, $urandom(), 1'b1);
    end
    foreach (wr_addr[i]) dat_access(1'b0, wr_addr[i], '0, 1'b1);

    // Fetches need execute permission
    ins_access(wr_addr[0], 1'b1);
    ins_access(wr_addr[2], 1'b1);
    ins_access(wr_addr[1], 1'b1);
    ins_access(TOHOST_ADDR, 1'b1);

    // MMIO reads and unmapped addresses
    dat_access(1'b0, TOHOST_ADDR, '0, 1'b1);
    dat_access(1'b0, UART_TX_ADDR, '0, 1'b1);
    dat_access(1'b0, UNMAPPED_ADDR, '0, 1'b1);
    ins_access(UNMAPPED_ADDR, 1'b1);

    // Host-catch writes next to live RAM words
    dat_access(1'b1, RAM_BASE, $urandom(), 1'b1);
    dat_access(1'b1, RAM_BASE + 32'h0000_0FFC, $urandom(), 1'b1);
    dat_access(1'b1, TOHOST_ADDR + 8, $urandom(), 1'b1);
    dat_access(1'b1, TOHOST_ADDR, $urandom(), 1'b1);
    dat_access(1'b1, UART_TX_ADDR, $urandom(), 1'b1);
    dat_access(1'b0, RAM_BASE + 32'h0000_0FFC, '0, 1'b1);
    dat_access(1'b0, RAM_BASE, '0, 1'b1);

    // Both ports on the same edge
    // Data is always served last here, so the fetch wins each tie
    for (int k = 0; k < 4; k++) begin
      fork
        ins_access(wr_addr[0], 1'b0);
        dat_access(k % 2 == 0, wr_addr[1], $urandom(), 1'b0);
      join
      assert (lat_seen[0] == ACK_LAT)
        else mismatch_error($sformatf("fetch ack after %0d edges, expected %0d",
                                      lat_seen[0], ACK_LAT));
    end

    repeat (4) @(negedge HCLK);
    if (ins_exp_q.size() == 0 && dat_exp_q.size() == 0 && tohost_exp_q.size() == 0 &&
        uart_exp_q.size() == 0 && uut.u_sva.err_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run("Responses or MMIO pulses still outstanding at the end of the run");
    end
  end

endmodule

//--- common/mem_sys_pkg.sv
// Memory subsystem definitions for widths, the PMA region table and the memory map
package mem_sys_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int PMA_CNT   = 4;
  localparam int PMA_SEL_W = 2;

  // RAM holds 2048 words, indexed by byte address bits 12:2
  localparam int RAM_WORDS = 2048;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  ////////////////////
  // Memory map
  ////////////////////
  localparam logic [ADDR_W-1:0] RAM_BASE     = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] RAM_LO_SIZE  = 32'h0000_1000;
  localparam logic [ADDR_W-1:0] RAM_TOP      = 32'h8000_2000;
  localparam logic [ADDR_W-1:0] TOHOST_ADDR  = 32'h8000_1000;
  localparam logic [ADDR_W-1:0] TOHOST_SIZE  = 32'h0000_0040;
  localparam logic [ADDR_W-1:0] UART_TX_ADDR = 32'h8000_1080;

  // Regions that carry the host-catch MMIO
  localparam logic [PMA_SEL_W-1:0] PMA_TOHOST = 2'd1;
  localparam logic [PMA_SEL_W-1:0] PMA_UART   = 2'd2;

  ////////////////////
  // PMA types
  ////////////////////
  // Same encoding as the address-match field of a RISC-V pmpcfg entry
  typedef enum logic [1:0] {
    PMA_OFF   = 2'd0,
    PMA_TOR   = 2'd1,
    PMA_NA4   = 2'd2,
    PMA_NAPOT = 2'd3
  } pma_mode_e;

  localparam logic MEM_MAIN = 1'b0;
  localparam logic MEM_IO   = 1'b1;

  typedef struct packed {
    logic rsvd;    // Spare, kept at zero
    logic mem_io;
    logic r;
    logic w;
    logic x;
  } pma_attr_t;

  ////////////////////
  // PMA region table
  ////////////////////
  // Word addresses; NAPOT size sits in the trailing ones
  localparam logic [ADDR_W-1:0] PMA_ADDR [PMA_CNT] = '{
    (RAM_BASE >> 2) | ((RAM_LO_SIZE >> 3) - 1),
    (TOHOST_ADDR >> 2) | ((TOHOST_SIZE >> 3) - 1),
    UART_TX_ADDR >> 2,
    RAM_TOP >> 2
  };

  localparam pma_mode_e PMA_MODE [PMA_CNT] = '{PMA_NAPOT, PMA_NAPOT, PMA_NA4, PMA_TOR};

  localparam pma_attr_t PMA_ATTR [PMA_CNT] = '{
    '{rsvd: 1'b0, mem_io: MEM_MAIN, r: 1'b1, w: 1'b1, x: 1'b1},
    '{rsvd: 1'b0, mem_io: MEM_IO,   r: 1'b0, w: 1'b1, x: 1'b0},
    '{rsvd: 1'b0, mem_io: MEM_IO,   r: 1'b0, w: 1'b1, x: 1'b0},
    '{rsvd: 1'b0, mem_io: MEM_MAIN, r: 1'b1, w: 1'b1, x: 1'b0}
  };

endpackage

//--- pma/pma_region_match.sv
// PMA region address comparator working in the region's own match mode
`timescale 1ns/1ns

module pma_region_match #(
  parameter int IDX = 0
) (
  input  logic [mem_sys_pkg::ADDR_W-1:0] acc_addr_i,
  output logic                           hit_o
);
  import mem_sys_pkg::*;

  logic [ADDR_W-1:0] waddr;
  logic [ADDR_W-1:0] tor_lo;
  logic [ADDR_W-1:0] napot_mask;

  // Table entries hold word addresses
  assign waddr = {2'b00, acc_addr_i[ADDR_W-1:2]};

  // TOR lower bound comes from the previous entry
  if (IDX == 0) begin : g_tor_base
    assign tor_lo = '0;
  end else begin : g_tor_prev
    assign tor_lo = PMA_ADDR[IDX-1];
  end

  // Trailing ones plus the first zero give the don't-care bits
  assign napot_mask = PMA_ADDR[IDX] ^ (PMA_ADDR[IDX] + 1'b1);

  always_comb begin
    case (PMA_MODE[IDX])
      PMA_TOR: begin
        hit_o = (waddr >= tor_lo) && (waddr < PMA_ADDR[IDX]);
      end
      PMA_NA4: begin
        hit_o = (waddr == PMA_ADDR[IDX]);
      end
      PMA_NAPOT: begin
        hit_o = ((waddr ^ PMA_ADDR[IDX]) & ~napot_mask) == '0;
      end
      PMA_OFF: begin
        hit_o = 1'b0;
      end
      default: begin
        hit_o = 1'b0;
      end
    endcase
  end

endmodule

//--- src/mem_access_unit.sv
// Memory access unit that checks PMA permissions and runs the RAM access or host-catch MMIO
`timescale 1ns/1ns

module mem_access_unit (
  input  logic                            HCLK,
  input  logic                            rst_n_i,

  input  logic                            acc_valid_i,
  input  logic                            acc_port_i,
  input  logic                            acc_we_i,
  input  logic [mem_sys_pkg::ADDR_W-1:0]  acc_addr_i,
  input  logic [mem_sys_pkg::DATA_W-1:0]  acc_wdata_i,
  input  logic [mem_sys_pkg::PMA_CNT-1:0] region_hit_i,

  output logic                            done_o,
  output logic [mem_sys_pkg::DATA_W-1:0]  done_rdata_o,
  output logic                            done_err_o,

  output logic                            tohost_valid_o,
  output logic [mem_sys_pkg::DATA_W-1:0]  tohost_data_o,
  output logic                            uart_valid_o,
  output logic [7:0]                      uart_char_o
);
  import mem_sys_pkg::*;

  logic [DATA_W-1:0]    ram [RAM_WORDS];
  logic [RAM_AW-1:0]    ram_idx;
  logic [PMA_SEL_W-1:0] sel;
  logic                 hit_any;
  pma_attr_t            attr;
  logic                 perm_ok;
  logic                 allowed;
  logic                 io_wr;
  logic                 rd_main;
  logic                 wr_main;
  logic                 tohost_hit;
  logic                 uart_hit;

  ////////////////////
  // Region select
  ////////////////////
  // Lowest index wins
  always_comb begin
    hit_any = 1'b0;
    sel     = '0;
    for (int i = PMA_CNT - 1; i >= 0; i--) begin
      if (region_hit_i[i]) begin
        hit_any = 1'b1;
        sel     = PMA_SEL_W'(i);
      end
    end
  end

  assign attr = PMA_ATTR[sel];

  // Fetch needs x, data write needs w, data read needs r
  always_comb begin
    if (!acc_port_i) begin
      perm_ok = attr.x;
    end else if (acc_we_i) begin
      perm_ok = attr.w;
    end else begin
      perm_ok = attr.r;
    end
  end

  assign allowed = hit_any & perm_ok;

  ////////////////////
  // Access decode
  ////////////////////
  assign ram_idx = acc_addr_i[RAM_AW+1:2];
  assign rd_main = allowed & ~attr.mem_io & ~acc_we_i;
  assign wr_main = allowed & ~attr.mem_io & acc_we_i;
  assign io_wr   = allowed & attr.mem_io & acc_we_i;

  assign tohost_hit = io_wr && (sel == PMA_TOHOST) &&
                      ((acc_addr_i & ~(TOHOST_SIZE - 1'b1)) == TOHOST_ADDR);
  assign uart_hit   = io_wr && (sel == PMA_UART) &&
                      (acc_addr_i[ADDR_W-1:2] == UART_TX_ADDR[ADDR_W-1:2]);

  // Pulses for done and the two MMIO catches
  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      done_o         <= 1'b0;
      tohost_valid_o <= 1'b0;
      uart_valid_o   <= 1'b0;
    end else begin
      done_o         <= acc_valid_i;
      tohost_valid_o <= acc_valid_i & tohost_hit;
      uart_valid_o   <= acc_valid_i & uart_hit;
    end
  end

  // RAM and response data
  always_ff @(posedge HCLK) begin
    if (acc_valid_i) begin
      if (wr_main) begin
        ram[ram_idx] <= acc_wdata_i;
      end
      // Only an allowed main read returns data
      done_rdata_o <= rd_main ? ram[ram_idx] : '0;
      done_err_o   <= ~allowed;
      if (tohost_hit) begin
        tohost_data_o <= acc_wdata_i;
      end
      if (uart_hit) begin
        uart_char_o <= acc_wdata_i[7:0];
      end
    end
  end

endmodule

//--- src/mem_sys_top.sv
// Memory subsystem top joining the port arbiter, the PMA matchers and the access unit
`timescale 1ns/1ns

module mem_sys_top (
  input  logic                           HCLK,
  input  logic                           rst_n_i,

  input  logic                           ins_req_i,
  input  logic [mem_sys_pkg::ADDR_W-1:0] ins_addr_i,
  output logic                           ins_ack_o,
  output logic [mem_sys_pkg::DATA_W-1:0] ins_rdata_o,
  output logic                           ins_err_o,

  input  logic                           dat_req_i,
  input  logic                           dat_we_i,
  input  logic [mem_sys_pkg::ADDR_W-1:0] dat_addr_i,
  input  logic [mem_sys_pkg::DATA_W-1:0] dat_wdata_i,
  output logic                           dat_ack_o,
  output logic [mem_sys_pkg::DATA_W-1:0] dat_rdata_o,
  output logic                           dat_err_o,

  output logic                           tohost_valid_o,
  output logic [mem_sys_pkg::DATA_W-1:0] tohost_data_o,
  output logic                           uart_valid_o,
  output logic [7:0]                     uart_char_o
);
  import mem_sys_pkg::*;

  logic               acc_valid;
  logic               acc_port;
  logic               acc_we;
  logic [ADDR_W-1:0]  acc_addr;
  logic [DATA_W-1:0]  acc_wdata;
  logic [PMA_CNT-1:0] region_hit;
  logic               done;
  logic [DATA_W-1:0]  done_rdata;
  logic               done_err;

  port_arbiter u_arbiter (
    .HCLK         (HCLK),
    .rst_n_i      (rst_n_i),
    .ins_req_i    (ins_req_i),
    .ins_addr_i   (ins_addr_i),
    .ins_ack_o    (ins_ack_o),
    .ins_rdata_o  (ins_rdata_o),
    .ins_err_o    (ins_err_o),
    .dat_req_i    (dat_req_i),
    .dat_we_i     (dat_we_i),
    .dat_addr_i   (dat_addr_i),
    .dat_wdata_i  (dat_wdata_i),
    .dat_ack_o    (dat_ack_o),
    .dat_rdata_o  (dat_rdata_o),
    .dat_err_o    (dat_err_o),
    .acc_valid_o  (acc_valid),
    .acc_port_o   (acc_port),
    .acc_we_o     (acc_we),
    .acc_addr_o   (acc_addr),
    .acc_wdata_o  (acc_wdata),
    .done_i       (done),
    .done_rdata_i (done_rdata),
    .done_err_i   (done_err)
  );

  ////////////////////
  // PMA matchers
  ////////////////////
  for (genvar i = 0; i < PMA_CNT; i++) begin : g_pma
    pma_region_match #(
      .IDX (i)
    ) u_match (
      .acc_addr_i (acc_addr),
      .hit_o      (region_hit[i])
    );
  end

  mem_access_unit u_access (
    .HCLK           (HCLK),
    .rst_n_i        (rst_n_i),
    .acc_valid_i    (acc_valid),
    .acc_port_i     (acc_port),
    .acc_we_i       (acc_we),
    .acc_addr_i     (acc_addr),
    .acc_wdata_i    (acc_wdata),
    .region_hit_i   (region_hit),
    .done_o         (done),
    .done_rdata_o   (done_rdata),
    .done_err_o     (done_err),
    .tohost_valid_o (tohost_valid_o),
    .tohost_data_o  (tohost_data_o),
    .uart_valid_o   (uart_valid_o),
    .uart_char_o    (uart_char_o)
  );

endmodule

//--- src/port_arbiter.sv
// Four-phase req/ack slave that serves the instruction and data ports one at a time
`timescale 1ns/1ns

module port_arbiter (
  input  logic                           HCLK,
  input  logic                           rst_n_i,

  input  logic                           ins_req_i,
  input  logic [mem_sys_pkg::ADDR_W-1:0] ins_addr_i,
  output logic                           ins_ack_o,
  output logic [mem_sys_pkg::DATA_W-1:0] ins_rdata_o,
  output logic                           ins_err_o,

  input  logic                           dat_req_i,
  input  logic                           dat_we_i,
  input  logic [mem_sys_pkg::ADDR_W-1:0] dat_addr_i,
  input  logic [mem_sys_pkg::DATA_W-1:0] dat_wdata_i,
  output logic                           dat_ack_o,
  output logic [mem_sys_pkg::DATA_W-1:0] dat_rdata_o,
  output logic                           dat_err_o,

  output logic                           acc_valid_o,
  output logic                           acc_port_o,
  output logic                           acc_we_o,
  output logic [mem_sys_pkg::ADDR_W-1:0] acc_addr_o,
  output logic [mem_sys_pkg::DATA_W-1:0] acc_wdata_o,

  input  logic                           done_i,
  input  logic [mem_sys_pkg::DATA_W-1:0] done_rdata_i,
  input  logic                           done_err_i
);
  import mem_sys_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_HOLD} state_e;

  state_e            state_q;
  logic [1:0]        req_q;
  logic [1:0]        pend;
  logic              win;
  logic              last_q;
  logic              owner_req;
  logic              accept;
  logic              capture;
  logic [DATA_W-1:0] rsp_rdata_q;
  logic              rsp_err_q;

  ////////////////////
  // Request sampling
  ////////////////////
  // Bit 0 is the instruction port, bit 1 the data port
  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      req_q <= '0;
    end else begin
      req_q <= {dat_req_i, ins_req_i};
    end
  end

  assign pend      = req_q & ~{dat_ack_o, ins_ack_o};
  // On a tie the port not served last goes first
  assign win       = (&pend) ? ~last_q : pend[1];
  assign owner_req = acc_port_o ? req_q[1] : req_q[0];
  assign accept    = (state_q == ST_IDLE) && (|pend);
  assign capture   = (state_q == ST_BUSY) && done_i;

  ////////////////////
  // Handshake FSM
  ////////////////////
  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      last_q      <= 1'b1;
      acc_valid_o <= 1'b0;
      ins_ack_o   <= 1'b0;
      dat_ack_o   <= 1'b0;
    end else begin
      acc_valid_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            acc_valid_o <= 1'b1;
            last_q      <= win;
            state_q     <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (done_i) begin
            ins_ack_o <= ~acc_port_o;
            dat_ack_o <= acc_port_o;
            state_q   <= ST_HOLD;
          end
        end
        ST_HOLD: begin
          // Release once the owning requester drops req
          if (!owner_req) begin
            ins_ack_o <= 1'b0;
            dat_ack_o <= 1'b0;
            state_q   <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request fields and the response held while ack is high
  always_ff @(posedge HCLK) begin
    if (accept) begin
      acc_port_o  <= win;
      acc_we_o    <= win & dat_we_i;
      acc_addr_o  <= win ? dat_addr_i : ins_addr_i;
      acc_wdata_o <= dat_wdata_i;
    end
    if (capture) begin
      rsp_rdata_q <= done_rdata_i;
      rsp_err_q   <= done_err_i;
    end
  end

  assign ins_rdata_o = rsp_rdata_q;
  assign ins_err_o   = rsp_err_q;
  assign dat_rdata_o = rsp_rdata_q;
  assign dat_err_o   = rsp_err_q;

endmodule

//--- vlog.f
common/mem_sys_pkg.sv
src/port_arbiter.sv
pma/pma_region_match.sv
src/mem_access_unit.sv
src/mem_sys_top.sv
bench/mem_sys_assertions.sv
bench/tb_mem_sys.sv
